/* conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// kernel geometry
`define KW_MAX      7       // largest odd kernel width
`define BITS_KW     3       // one clr code per lane
`define BITS_KW2    2       // holds kw/2 for every kernel up to KW_MAX

// datapath lanes
`define MEMBERS     12      // parallel pixel lanes per beat

// row counters
`define BITS_COLS   8       // column count of one row
`define BITS_CIN    6       // input channels per column

// payload widths
`define PIX_W       8       // unsigned pixel
`define SUM_W       16      // channel sum per lane

// a lane sum of 2**BITS_CIN full scale pixels needs
// PIX_W + BITS_CIN bits, which SUM_W covers with headroom

`endif

/* conv_pkg.sv */
`default_nettype none

`include "conv_macros.svh"

package conv_pkg;

    // row config, carried in the low bits of the first beat of a row
    typedef struct packed {
        logic [`BITS_KW2-1:0]  kw2;           // kernel width / 2
        logic [`BITS_COLS-1:0] cols_1;        // columns - 1
        logic [`BITS_CIN-1:0]  cin_1;         // input channels - 1
    } conv_cfg_t;

    // per beat side band, formed by conv_ctrl
    typedef struct packed {
        logic [`BITS_KW2-1:0]  kw2;           // kernel of the row this beat belongs to
        logic                  is_config;     // beat is the row config
        logic                  is_cin_last;   // last channel of a column
        logic                  is_cols_1_k2;  // column cols-1-kw/2
    } conv_user_t;

    // one data word, decoded as pixels on data beats and as config on the first beat
    typedef union packed {
        logic [`MEMBERS-1:0][`PIX_W-1:0] pix;    // one pixel per lane
        struct packed {
            logic [`MEMBERS*`PIX_W-$bits(conv_cfg_t)-1:0] rsvd;  // ignored on config beats
            conv_cfg_t                                   word;
        } cfg;
    } conv_beat_u;

    // one completed column
    typedef struct packed {
        logic [`MEMBERS-1:0][`SUM_W-1:0]   sum;    // channel sums per lane
        logic [`MEMBERS-1:0]               mask;   // lanes holding a full window
        logic [`MEMBERS-1:0][`BITS_KW-1:0] clr;    // center/left/right edge codes
    } conv_result_t;

endpackage

`default_nettype wire

/* conv_ctrl.sv */
`default_nettype none

`include "conv_macros.svh"

module conv_ctrl import conv_pkg::*; (
    input  wire logic                          aclk,
    input  wire logic                          aclken,       // stage clock enable
    input  wire logic                          rst,
    input  wire logic                          s_valid,      // one strobe per beat
    input  wire logic                          s_is_config,  // first beat of a row
    input  wire conv_beat_u                    s_beat,
    output logic                               u_valid,
    output conv_user_t                         u_user,
    output logic [`MEMBERS-1:0][`PIX_W-1:0]    u_pix
);

    localparam int BITS_COLS = `BITS_COLS;

    conv_cfg_t              cfg;            // config of the current row
    logic [`BITS_CIN-1:0]   cin_cnt;        // channel within the column
    logic [`BITS_COLS-1:0]  col_cnt;        // column within the row
    logic [`BITS_COLS-1:0]  col_1_k2;       // column cols-1-kw/2
    logic                   take;           // beat accepted at this edge
    logic                   cin_last;       // beat closes its column
    logic                   col_last;       // column closes the row
    conv_user_t             user_next;      // flags for the incoming beat

    assign take     = aclken && s_valid;
    assign cin_last = (cin_cnt == cfg.cin_1);
    assign col_last = (col_cnt == cfg.cols_1);
    assign col_1_k2 = cfg.cols_1 - BITS_COLS'(cfg.kw2);   // right edge starts here

    // flags follow the beat, a config beat carries its own new kernel
    always_comb begin
        user_next.kw2          = s_is_config ? s_beat.cfg.word.kw2 : cfg.kw2;
        user_next.is_config    = s_is_config;
        user_next.is_cin_last  = !s_is_config && cin_last;
        user_next.is_cols_1_k2 = !s_is_config && (col_cnt == col_1_k2);
    end

    // config latch and channel / column counters
    always_ff @(posedge aclk) begin
        if (rst) begin
            cfg     <= '0;
            cin_cnt <= '0;
            col_cnt <= '0;
        end else if (take) begin
            if (s_is_config) begin
                cfg     <= s_beat.cfg.word;       // new row
                cin_cnt <= '0;
                col_cnt <= '0;
            end else if (cin_last) begin
                cin_cnt <= '0;                    // next column
                col_cnt <= col_last ? '0 : col_cnt + 1'b1;
            end else begin
                cin_cnt <= cin_cnt + 1'b1;
            end
        end
    end

    // registered strobe and side band, one cycle behind the input beat
    always_ff @(posedge aclk) begin
        if (rst) begin
            u_valid <= 1'b0;
            u_user  <= '0;
        end else if (aclken) begin
            u_valid <= s_valid;
            if (s_valid) begin
                u_user <= user_next;
            end
        end
    end

    // pixel view of the beat, meaningless on config beats
    always_ff @(posedge aclk) begin
        if (take) begin
            u_pix <= s_beat.pix;
        end
    end

endmodule

`default_nettype wire

/* pad_filter.sv */
`default_nettype none

`include "conv_macros.svh"

module pad_filter import conv_pkg::*; (
    input  wire logic                          aclk,
    input  wire logic                          aclken,
    input  wire logic                          rst,
    input  wire logic                          valid_in,
    input  wire conv_user_t                    user_in,
    output logic [`MEMBERS-1:0]                mask_full,   // lanes with a complete window
    output logic [`MEMBERS-1:0][`BITS_KW-1:0]  clr          // 0 center, odd left, even right
);

    localparam int MEMBERS = `MEMBERS;
    localparam int KW2_MAX = `KW_MAX / 2;     // 3 for kw up to 7
    localparam int BITS_KW = `BITS_KW;

    logic [`BITS_KW2-1:0]   kw2;              // kw/2 of the beat, selects the lookup
    logic                   reg_en;           // config or last channel beat
    logic [KW2_MAX:1]       col_start;        // bit k high in column k-1
    logic [KW2_MAX:1]       col_start_in;
    logic [KW2_MAX:1]       col_end;          // bit kw2 high in the last column
    logic [KW2_MAX:1]       col_end_in;
    logic [KW2_MAX:0]       col_end_x;        // bit 0 stays low for kw = 1
    logic [BITS_KW-1:0]     clr_left_in;
    logic [BITS_KW-1:0]     clr_left;         // left code of the current column

    assign kw2       = user_in.kw2;
    assign reg_en    = aclken && valid_in && (user_in.is_cin_last || user_in.is_config);
    assign col_end_x = {col_end, 1'b0};

    // next state of the one-hot edge shifters
    // a config beat restarts both so nothing carries into the next row
    always_comb begin
        col_end_in[1]   = user_in.is_cols_1_k2 && (kw2 != '0);
        col_start_in[1] = user_in.is_config ? (kw2 != '0) : col_end_x[kw2];  // wraps at row end
        for (int k = 2; k <= KW2_MAX; k++) begin
            col_end_in[k]   = user_in.is_config ? 1'b0 : col_end[k-1];
            col_start_in[k] = user_in.is_config ? 1'b0 : col_start[k-1];
        end
    end

    // left code for the coming column c is 2c+1 while c < kw2
    always_comb begin
        clr_left_in = '0;
        for (int k = 1; k <= KW2_MAX; k++) begin
            if (col_start_in[k] && (k <= int'(kw2))) begin
                clr_left_in = BITS_KW'(2 * k - 1);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            col_start <= '0;
            col_end   <= '0;
            clr_left  <= BITS_KW'(1);
        end else if (reg_en) begin
            col_start <= col_start_in;
            col_end   <= col_end_in;
            clr_left  <= clr_left_in;
        end
    end

    for (genvar m = 0; m < MEMBERS; m++) begin : g_lane
        logic [KW2_MAX:0]   allow;            // full mask per kernel
        logic [KW2_MAX:0]   next_full;        // lane sits just before a full lane
        logic               masked_en;
        logic [KW2_MAX:1]   end_masked;       // end shifter seen by this lane
        logic [BITS_KW-1:0] clr_right;

        assign allow[0]     = 1'b1;           // kw = 1 passes every lane
        assign next_full[0] = 1'b1;

        for (genvar k2 = 1; k2 <= KW2_MAX; k2++) begin : g_kw
            localparam int KW = 2 * k2 + 1;

            logic full_lane;                  // window ends on this lane
            logic unused_lane;                // beyond the last whole window
            logic start_cols;                 // first kw/2 columns
            logic last_col;
            logic last_malformed;             // lane misses data at the right pad

            assign full_lane      = (m % KW) == KW - 1;
            assign unused_lane    = m >= (MEMBERS / KW) * KW;
            assign start_cols     = |col_start[k2:1];
            assign last_col       = col_end[k2];
            assign last_malformed = (m % KW) < k2;
            assign next_full[k2]  = (m % KW) == KW - 2;

            assign allow[k2] = (full_lane && !start_cols)
                             || (last_col && !last_malformed && !unused_lane);
        end

        // only lanes in front of a full lane track the right edge
        assign masked_en = aclken && valid_in
                         && ((next_full[kw2] && user_in.is_cin_last) || user_in.is_config);

        always_ff @(posedge aclk) begin
            if (rst) begin
                end_masked <= '0;
            end else if (masked_en) begin
                end_masked <= col_end_in;     // cleared by the config beat
            end
        end

        // right code is 2 in the last column, 4 one before, and so on
        always_comb begin
            clr_right = '0;
            for (int k = 1; k <= KW2_MAX; k++) begin
                if (end_masked[k] && (k <= int'(kw2))) begin
                    clr_right = BITS_KW'(2 * (int'(kw2) - k + 1));
                end
            end
        end

        assign mask_full[m] = allow[kw2] | user_in.is_config;
        assign clr[m]       = clr_left | clr_right;
    end

endmodule

`default_nettype wire

/* lane_accum.sv */
`default_nettype none

`include "conv_macros.svh"

module lane_accum import conv_pkg::*; (
    input  wire logic                          aclk,
    input  wire logic                          aclken,
    input  wire logic                          rst,
    input  wire logic                          u_valid,
    input  wire conv_user_t                    u_user,
    input  wire logic [`MEMBERS-1:0][`PIX_W-1:0]    u_pix,
    input  wire logic [`MEMBERS-1:0]                mask_full,
    input  wire logic [`MEMBERS-1:0][`BITS_KW-1:0]  clr,
    output logic                               m_valid,     // one pulse per column
    output conv_result_t                       m_result
);

    localparam int MEMBERS = `MEMBERS;
    localparam int SUM_W   = `SUM_W;

    logic [MEMBERS-1:0][SUM_W-1:0] acc;       // running channel sums
    logic [MEMBERS-1:0][SUM_W-1:0] acc_next;
    logic                          first_cin; // next data beat opens a column
    logic                          data_beat; // pixel beat taken at this edge
    logic                          col_done;  // column completes at this edge

    assign data_beat = aclken && u_valid && !u_user.is_config;
    assign col_done  = data_beat && u_user.is_cin_last;

    // sums restart on the first channel of each column
    always_comb begin
        for (int m = 0; m < MEMBERS; m++) begin
            acc_next[m] = (first_cin ? SUM_W'(0) : acc[m]) + SUM_W'(u_pix[m]);
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            first_cin <= 1'b1;
        end else if (aclken && u_valid) begin
            first_cin <= u_user.is_config || u_user.is_cin_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (data_beat) begin
            acc <= acc_next;
        end
    end

    // result strobe, held while aclken is low
    always_ff @(posedge aclk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (aclken) begin
            m_valid <= col_done;
        end
    end

    // sums of the closing beat together with this column's mask and codes
    always_ff @(posedge aclk) begin
        if (col_done) begin
            m_result.sum  <= acc_next;
            m_result.mask <= mask_full;
            m_result.clr  <= clr;
        end
    end

endmodule

`default_nettype wire

/* conv_pad_top.sv */
`default_nettype none

`include "conv_macros.svh"

module conv_pad_top import conv_pkg::*; (
    input  wire logic       aclk,
    input  wire logic       aclken,
    input  wire logic       rst,
    input  wire logic       s_valid,
    input  wire logic       s_is_config,
    input  wire conv_beat_u s_beat,
    output logic            m_valid,
    output conv_result_t    m_result
);

    logic                               u_valid;    // registered beat strobe
    conv_user_t                         u_user;     // registered side band
    logic [`MEMBERS-1:0][`PIX_W-1:0]    u_pix;
    logic [`MEMBERS-1:0]                mask_full;  // same cycle as u_user
    logic [`MEMBERS-1:0][`BITS_KW-1:0]  clr;

    conv_ctrl u_conv_ctrl (
        .aclk        (aclk),
        .aclken      (aclken),
        .rst         (rst),
        .s_valid     (s_valid),
        .s_is_config (s_is_config),
        .s_beat      (s_beat),
        .u_valid     (u_valid),
        .u_user      (u_user),
        .u_pix       (u_pix)
    );

    pad_filter u_pad_filter (
        .aclk      (aclk),
        .aclken    (aclken),
        .rst       (rst),
        .valid_in  (u_valid),
        .user_in   (u_user),
        .mask_full (mask_full),
        .clr       (clr)
    );

    lane_accum u_lane_accum (
        .aclk      (aclk),
        .aclken    (aclken),
        .rst       (rst),
        .u_valid   (u_valid),
        .u_user    (u_user),
        .u_pix     (u_pix),
        .mask_full (mask_full),
        .clr       (clr),
        .m_valid   (m_valid),
        .m_result  (m_result)
    );

endmodule

`default_nettype wire

/* tb_conv_pad.sv */
`default_nettype none

`include "conv_macros.svh"

module tb_conv_pad import conv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEMBERS  = `MEMBERS;
    localparam int PIX_W    = `PIX_W;
    localparam int SUM_W    = `SUM_W;
    localparam int BITS_KW  = `BITS_KW;
    localparam int KW2_W    = `BITS_KW2;
    localparam int COLS_W   = `BITS_COLS;
    localparam int CIN_W    = `BITS_CIN;
    localparam int ACCEPT_TRIES = 64;     // cycles a beat may wait for aclken
    localparam int DRAIN_TRIES  = 200;    // cycles for the last columns to come out

    // expected column, clr_kind 0 all zero, 1 all odd, 2 not checked
    typedef struct packed {
        logic [MEMBERS-1:0][SUM_W-1:0] sum;
        logic [MEMBERS-1:0]            mask;
        logic [1:0]                    clr_kind;
    } exp_t;

    logic          aclk;
    logic          aclken;
    logic          rst;
    logic          s_valid;
    logic          s_is_config;
    conv_beat_u    s_beat;
    logic          m_valid;
    conv_result_t  m_result;
    logic          take_res;             // result consumed at the next rising edge

    integer        seed = 32'h1de9_30e4;
    int            errors = 0;
    int            timeouts = 0;
    int            n_sent = 0;           // columns pushed into the model
    int            n_results = 0;        // m_valid pulses seen
    int            exp_cnt = 0;
    exp_t          exp_q[$];             // expected columns in order
    exp_t          exp_head = '0;        // front of exp_q

    conv_pad_top u_conv_pad_top (
        .aclk        (aclk),
        .aclken      (aclken),
        .rst         (rst),
        .s_valid     (s_valid),
        .s_is_config (s_is_config),
        .s_beat      (s_beat),
        .m_valid     (m_valid),
        .m_result    (m_result)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;         // 8 ns period
    end

    assign take_res = aclken && m_valid;

    // stall roughly one cycle in four
    function automatic logic rand_enable();
        return ($random(seed) & 3) != 0;
    endfunction

    function automatic logic [MEMBERS-1:0] expected_mask(input int kw, input int col,
                                                        input int cols);
        logic [MEMBERS-1:0] mask;
        int                 kw2;
        int                 whole;
        kw2   = kw / 2;
        whole = (MEMBERS / kw) * kw;      // lanes covered by whole windows
        mask  = '0;
        for (int m = 0; m < MEMBERS; m++) begin
            if (kw == 1) begin
                mask[m] = 1'b1;
            end else if (((m % kw) == kw - 1) && (col >= kw2)) begin
                mask[m] = 1'b1;           // window ends on this lane
            end else if ((col == cols - 1) && ((m % kw) >= kw2) && (m < whole)) begin
                mask[m] = 1'b1;           // right padded last column
            end
        end
        return mask;
    endfunction

    function automatic logic [1:0] clr_kind_of(input int kw, input int col, input int cols);
        if (kw == 1) begin
            return 2'd0;
        end else if (col < kw / 2) begin
            return 2'd1;                  // left edge
        end else if ((col >= kw) && (col <= cols - 1 - kw)) begin
            return 2'd0;                  // well inside the row
        end
        return 2'd2;
    endfunction

    function automatic logic lanes_odd(input logic [MEMBERS-1:0][BITS_KW-1:0] codes);
        logic ok;
        ok = 1'b1;
        for (int m = 0; m < MEMBERS; m++) begin
            ok = ok && codes[m][0];
        end
        return ok;
    endfunction

    task automatic refresh_head();
        exp_cnt = exp_q.size();
        if (exp_cnt > 0) begin
            exp_head = exp_q[0];
        end else begin
            exp_head = '0;
        end
    endtask

    task automatic idle_cycle();
        s_valid <= 1'b0;
        aclken  <= rand_enable();
        @(posedge aclk);
    endtask

    // holds the beat until an edge with aclken high takes it
    task automatic send_beat(input logic is_cfg, input conv_beat_u beat);
        int tries;
        if (($random(seed) & 7) == 0) begin
            idle_cycle();                 // occasional gap between beats
        end
        s_valid     <= 1'b1;
        s_is_config <= is_cfg;
        s_beat      <= beat;
        aclken      <= rand_enable();
        tries = 0;
        @(posedge aclk);
        while (!aclken && tries < ACCEPT_TRIES) begin
            aclken <= rand_enable();
            tries++;
            @(posedge aclk);
        end
        if (!aclken) begin
            timeouts++;
            $display("timeout: a beat was not accepted within %0d cycles", ACCEPT_TRIES);
        end
    endtask

    task automatic send_row(input int kw, input int cols, input int cin);
        conv_beat_u                    beat;
        logic [MEMBERS-1:0][SUM_W-1:0] sums;
        logic [PIX_W-1:0]              p;
        exp_t                          e;
        beat = '0;
        beat.cfg.word.kw2    = KW2_W'(kw / 2);
        beat.cfg.word.cols_1 = COLS_W'(cols - 1);
        beat.cfg.word.cin_1  = CIN_W'(cin - 1);
        send_beat(1'b1, beat);
        for (int c = 0; c < cols; c++) begin
            sums = '0;
            for (int ch = 0; ch < cin; ch++) begin
                for (int m = 0; m < MEMBERS; m++) begin
                    p            = PIX_W'($random(seed));
                    beat.pix[m]  = p;
                    sums[m]      = sums[m] + SUM_W'(p);
                end
                send_beat(1'b0, beat);
            end
            e.sum      = sums;
            e.mask     = expected_mask(kw, c, cols);
            e.clr_kind = clr_kind_of(kw, c, cols);
            exp_q.push_back(e);           // at least two edges before its m_valid
            n_sent++;
            refresh_head();
        end
    endtask

    // consume the front column when the DUT hands it over
    always @(posedge aclk) begin
        if (!rst && aclken && m_valid) begin
            n_results++;
            if (exp_q.size() > 0) begin
                exp_q.delete(0);
            end
            refresh_head();
        end
    end

    // checks at the falling edge, where outputs and the model head are stable
    a_pending: assert property (@(negedge aclk) disable iff (rst)
        take_res |-> (exp_cnt > 0))
    else begin
        errors++;
        $display("m_valid pulsed with no column pending");
    end

    a_sum: assert property (@(negedge aclk) disable iff (rst)
        (take_res && exp_cnt > 0) |-> (m_result.sum == exp_head.sum))
    else begin
        errors++;
        $display("ERR m_result.sum expected %h actual %h", exp_head.sum, m_result.sum);
    end

    a_mask: assert property (@(negedge aclk) disable iff (rst)
        (take_res && exp_cnt > 0) |-> (m_result.mask == exp_head.mask))
    else begin
        errors++;
        $display("ERR m_result.mask expected %h actual %h", exp_head.mask, m_result.mask);
    end

    a_clr_zero: assert property (@(negedge aclk) disable iff (rst)
        (take_res && exp_cnt > 0 && exp_head.clr_kind == 2'd0) |-> (m_result.clr == '0))
    else begin
        errors++;
        $display("ERR m_result.clr expected %h actual %h", '0, m_result.clr);
    end

    a_clr_odd: assert property (@(negedge aclk) disable iff (rst)
        (take_res && exp_cnt > 0 && exp_head.clr_kind == 2'd1) |-> lanes_odd(m_result.clr))
    else begin
        errors++;
        $display("ERR m_result.clr expected odd codes in every lane, actual %h",
                 m_result.clr);
    end

    initial begin
        int tries;
        rst         = 1'b1;
        aclken      = 1'b1;
        s_valid     = 1'b0;
        s_is_config = 1'b0;
        s_beat      = '0;
        repeat (2) @(posedge aclk);
        rst <= 1'b0;

        // back to back rows, each with its own kernel
        send_row(3, 9, 3);
        send_row(7, 16, 2);
        send_row(5, 12, 4);
        send_row(1, 6, 1);

        s_valid <= 1'b0;
        tries = 0;
        while (exp_cnt > 0 && tries < DRAIN_TRIES) begin
            aclken <= rand_enable();
            tries++;
            @(posedge aclk);
        end
        if (exp_cnt > 0) begin
            timeouts++;
            $display("timeout: %0d columns still missing at the output", exp_cnt);
        end
        aclken <= 1'b1;
        repeat (8) @(posedge aclk);       // room for a stray pulse

        if (n_results != n_sent) begin
            errors++;
            $display("ERR m_valid count expected %h actual %h", n_sent, n_results);
        end
        $display("check errors %0d, timeouts %0d, columns %0d of %0d",
                 errors, timeouts, n_results, n_sent);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
conv_pkg.sv
conv_ctrl.sv
pad_filter.sv
lane_accum.sv
conv_pad_top.sv
tb_conv_pad.sv
